/* tb.f */
+incdir+source
+incdir+tests
source/execPkg.sv
source/instrDecoder.sv
source/aluDecoder.sv
source/aluCore.sv
source/mulDivUnit.sv
source/resultStage.sv
source/execTop.sv
tests/execTopTb.sv

/* tests/execTests.svh */
`ifndef EXEC_TESTS_SVH
`define EXEC_TESTS_SVH

// Fixed 2-cycle latency from strobe to result
task automatic runAlu(input logic [31:0] ins, input logic [31:0] a, input logic [31:0] b,
                      input string what);
    issue(ins, a, b);
    nextCycle();
    nextCycle();
    checkEq(resultValid, 1'b1, {what, " resultValid"});
    checkOutputs(ins, a, b, what);
endtask

task automatic runMd(input logic [31:0] ins, input logic [31:0] a, input logic [31:0] b,
                     input string what);
    issue(ins, a, b);
    nextCycle();
    waitResult(what);
    checkOutputs(ins, a, b, what);
endtask

task automatic testAluOps();
    logic [31:0] r;
    for (int k = 0; k < 8; k++) begin
        runAlu(encR(7'h00, 3'(k), opReg), nextRand(), nextRand(), $sformatf("OP f3 %0d", k));
        r = nextRand();
        runAlu(encI((k == 1 || k == 5) ? {7'b0, r[4:0]} : r[11:0], 3'(k), opImm),
               nextRand(), 32'h0, $sformatf("OP-IMM f3 %0d", k));
    end
    runAlu(encR(7'h20, 3'd0, opReg), nextRand(), nextRand(), "SUB");
    runAlu(encR(7'h20, 3'd5, opReg), nextRand() | 32'h8000_0000, nextRand(), "SRA");
    runAlu(encI({7'h20, 5'd7}, 3'd5, opImm), nextRand() | 32'h8000_0000, 32'h0, "SRAI");
    runAlu(encI(12'h405, 3'd0, opImm), nextRand(), nextRand(), "ADDI bit 30");  // Must add
endtask

task automatic testBackToBack();
    logic [31:0] ins [4];
    logic [31:0] av [4];
    logic [31:0] bv [4];
    for (int k = 0; k < 4; k++) begin
        ins[k] = encR((k == 2) ? 7'h20 : 7'h00, 3'(k * 2), opReg);
        av[k]  = nextRand();
        bv[k]  = nextRand();
    end
    for (int k = 0; k < 5; k++) begin
        if (k < 4) issue(ins[k], av[k], bv[k]);
        nextCycle();
        if (k >= 1) begin
            checkEq(resultValid, 1'b1, $sformatf("back-to-back %0d valid", k - 1));
            checkOutputs(ins[k-1], av[k-1], bv[k-1], $sformatf("back-to-back %0d", k - 1));
        end
    end
    nextCycle();
    checkEq(resultValid, 1'b0, "back-to-back trailing valid");
endtask

task automatic testBranches();
    int          fList [6] = '{0, 1, 4, 5, 6, 7};
    logic [31:0] aList [4] = '{32'h1234_5678, 32'hFFFF_FFF0, 32'd5, 32'd3};
    logic [31:0] bList [4] = '{32'h1234_5678, 32'd5, 32'hFFFF_FFF0, 32'd7};
    for (int f = 0; f < 6; f++) begin
        for (int p = 0; p < 4; p++) begin
            runAlu(encR(7'h00, 3'(fList[f]), opBranch), aList[p], bList[p],
                   $sformatf("branch f3 %0d pair %0d", fList[f], p));
        end
    end
endtask

task automatic testAddress();
    runAlu(encI(12'hFFC, 3'd2, opLoad), 32'h0000_1000, 32'h0, "load imm -4");
    runAlu(encS(12'hF9C, 3'd2, opStore), 32'h0000_2000, nextRand(), "store imm -100");
    runAlu(encS(12'h800, 3'd0, opStore), nextRand(), nextRand(), "store imm -2048");
    runAlu(encI(12'hA55, 3'd0, opLoad), nextRand(), 32'h0, "load imm negative");
endtask

task automatic testMulDiv();
    logic [31:0] aList [5];
    logic [31:0] bList [5];
    aList = '{nextRand(), nextRand(), nextRand(), 32'h8000_0000, 32'hFFFF_FFF9};
    bList = '{nextRand(), nextRand(), 32'h0, 32'hFFFF_FFFF, 32'd2};  // Includes div by zero
    for (int k = 0; k < 8; k++) begin
        for (int p = 0; p < 5; p++) begin
            runMd(encR(7'h01, 3'(k), opReg), aList[p], bList[p],
                  $sformatf("M f3 %0d pair %0d", k, p));
        end
    end
endtask

task automatic testIllegalAndBusy();
    logic [31:0] divIns;
    logic [31:0] a;
    logic [31:0] b;
    runAlu(encI(12'h123, 3'd0, 7'b0110111), nextRand(), nextRand(), "unknown opcode");
    runAlu(encR(7'h01, 3'd0, opImm), nextRand(), nextRand(), "M funct7 on OP-IMM");
    divIns = encR(7'h01, 3'd5, opReg);
    a      = nextRand();
    b      = nextRand() | 32'd1;
    issue(divIns, a, b);
    nextCycle();
    nextCycle();
    checkEq(busy, 1'b1, "busy before stray strobe");
    issue(encR(7'h00, 3'd0, opReg), nextRand(), nextRand());  // Dropped by the DUT
    nextCycle();
    waitResult("DIVU under stray strobe");
    checkOutputs(divIns, a, b, "DIVU under stray strobe");
    repeat (4) begin
        nextCycle();
        checkEq(resultValid, 1'b0, "extra resultValid after stray strobe");
    end
endtask

`endif

/* tests/execTopTb.sv */
`timescale 1ns/1ns
`include "exec_config.svh"

module execTopTb;
    import execPkg::*;

    localparam int NumInstr  = 100;  // Instructions the tests issue, rounded up
    localparam int MaxCycles = NumInstr * (`DIV_STEPS + 8);

    logic             clk;
    logic             arstN;
    logic             instrValid;
    logic [`XLEN-1:0] instr;
    logic [`XLEN-1:0] rs1Val;
    logic [`XLEN-1:0] rs2Val;
    logic [`XLEN-1:0] result;
    logic             resultValid;
    logic             branchTaken;
    logic             illegalInstr;
    logic             busy;
    logic [31:0]      rngState;
    int               cycleCount = 0;

    execTop i_execTop (
        .clk          (clk),
        .arstN        (arstN),
        .instrValid   (instrValid),
        .instr        (instr),
        .rs1Val       (rs1Val),
        .rs2Val       (rs2Val),
        .result       (result),
        .resultValid  (resultValid),
        .branchTaken  (branchTaken),
        .illegalInstr (illegalInstr),
        .busy         (busy)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 ns period
    end

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > MaxCycles) begin
            $display("Timeout: the tests ran longer than %0d cycles", MaxCycles);
            $display("Simulation FAILED");
            $fatal(1, "Run aborted on timeout");
        end
    end

    function automatic logic [31:0] nextRand();
        logic [31:0] x;
        x = rngState;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rngState = x;
        return x;
    endfunction

    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [6:0] opc);
        return {f7, 5'd2, 5'd1, f3, 5'd3, opc};
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [2:0] f3,
                                         input logic [6:0] opc);
        return {imm, 5'd1, f3, 5'd3, opc};
    endfunction

    function automatic logic [31:0] encS(input logic [11:0] imm, input logic [2:0] f3,
                                         input logic [6:0] opc);
        return {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], opc};
    endfunction

    // Unknown opcode, or M funct7 outside OP
    function automatic logic refIllegal(input logic [31:0] ins);
        logic [6:0] opc;
        logic       known;
        opc   = ins[6:0];
        known = (opc == opReg) || (opc == opImm) || (opc == opBranch) ||
                (opc == opLoad) || (opc == opStore);
        return !known || (ins[31:25] == 7'b0000001 && opc != opReg);
    endfunction

    function automatic logic refTaken(input logic [31:0] ins, input logic [31:0] a,
                                      input logic [31:0] b);
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        sa = a;
        sb = b;
        if (ins[6:0] != opBranch) return 1'b0;
        case (ins[14:12])
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return sa < sb;
            3'd5:    return sa >= sb;
            3'd6:    return a < b;
            3'd7:    return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] refResult(input logic [31:0] ins, input logic [31:0] a,
                                              input logic [31:0] b);
        logic [6:0]         opc;
        logic [2:0]         f3;
        logic [31:0]        immI;
        logic [31:0]        src;
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        logic signed [63:0] wa;
        logic signed [63:0] wb;
        logic signed [63:0] prod;
        logic               ovf;
        opc  = ins[6:0];
        f3   = ins[14:12];
        immI = {{20{ins[31]}}, ins[31:20]};
        src  = (opc == opReg) ? b : immI;
        sa   = a;
        sb   = b;
        ovf  = (a == 32'h8000_0000) && (b == 32'hFFFF_FFFF);
        if (refIllegal(ins)) return '0;
        if (opc == opLoad) return a + immI;
        if (opc == opStore) return a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
        if (opc == opBranch) begin
            if (!f3[2]) return a - b;  // BEQ and BNE report the difference
            return f3[1] ? {31'b0, a < b} : {31'b0, sa < sb};
        end
        if (ins[31:25] == 7'b0000001) begin
            wa = f3[1] && f3[0] ? $signed({32'b0, a}) : sa;  // Only MULHU treats A unsigned
            wb = (f3 == 3'd1) ? sb : $signed({32'b0, b});
            prod = wa * wb;
            case (f3)
                3'd0: return a * b;
                3'd4: begin
                    if (b == 0) return '1;
                    if (ovf) return a;
                    return sa / sb;
                end
                3'd5: return (b == 0) ? '1 : a / b;
                3'd6: begin
                    if (b == 0) return a;
                    if (ovf) return '0;
                    return sa % sb;  // Sign follows the dividend
                end
                3'd7: return (b == 0) ? a : a % b;
                default: return prod[63:32];
            endcase
        end
        case (f3)
            3'd0: return (opc == opReg && ins[30]) ? a - b : a + src;
            3'd1: return a << src[4:0];
            3'd2: return {31'b0, sa < $signed(src)};
            3'd3: return {31'b0, a < src};
            3'd4: return a ^ src;
            3'd5: return ins[30] ? $unsigned(sa >>> src[4:0]) : a >> src[4:0];
            3'd6: return a | src;
            default: return a & src;
        endcase
    endfunction

    task automatic checkEq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("FAIL %0t ns: %s got %h expected %h", $time, what, got, exp);
            $display("Simulation FAILED");
            $fatal(1, "Value mismatch");
        end
    endtask

    // Outputs are sampled and inputs driven 5 ns after the edge
    task automatic nextCycle();
        @(posedge clk);
        #5;
        instrValid = 1'b0;
    endtask

    task automatic issue(input logic [31:0] ins, input logic [31:0] a, input logic [31:0] b);
        instrValid = 1'b1;
        instr      = ins;
        rs1Val     = a;
        rs2Val     = b;
    endtask

    task automatic checkOutputs(input logic [31:0] ins, input logic [31:0] a,
                                input logic [31:0] b, input string what);
        checkEq(result, refResult(ins, a, b), {what, " result"});
        checkEq(branchTaken, refTaken(ins, a, b), {what, " branchTaken"});
        checkEq(illegalInstr, refIllegal(ins), {what, " illegalInstr"});
    endtask

    task automatic waitResult(input string what);
        int n;
        n = 0;
        while (resultValid !== 1'b1) begin
            if (n > `DIV_STEPS + 4) begin
                $display("No result for %s after %0d cycles", what, n);
                $display("Simulation FAILED");
                $fatal(1, "Result never arrived");
            end
            if (n > 0) checkEq(busy, 1'b1, {what, " busy while in flight"});
            nextCycle();
            n++;
        end
        checkEq(busy, 1'b0, {what, " busy with result"});
    endtask

    `include "execTests.svh"

    initial begin
        arstN      = 1'b0;
        instrValid = 1'b0;
        instr      = '0;
        rs1Val     = '0;
        rs2Val     = '0;
        rngState   = 32'd12105;
        repeat (4) @(posedge clk);
        #5;
        arstN = 1'b1;
        checkEq(resultValid, 1'b0, "resultValid after reset");
        checkEq(busy, 1'b0, "busy after reset");
        checkEq(result, '0, "result after reset");
        testAluOps();
        testBackToBack();
        testBranches();
        testAddress();
        testMulDiv();
        testIllegalAndBusy();
        $display("Simulation PASSED");
        $finish;
    end

endmodule

/* source/execTop.sv */
`timescale 1ns/1ns
`include "exec_config.svh"

module execTop (
    input  logic             clk,
    input  logic             arstN,
    input  logic             instrValid,
    input  logic [`XLEN-1:0] instr,
    input  logic [`XLEN-1:0] rs1Val,
    input  logic [`XLEN-1:0] rs2Val,
    output logic [`XLEN-1:0] result,
    output logic             resultValid,
    output logic             branchTaken,
    output logic             illegalInstr,
    output logic             busy
);
    import execPkg::*;

    opcodeT           opcode;
    logic [2:0]       funct3;
    logic             funct7b5;
    aluOpT            aluOp;
    aluCtrlT          aluCtrl;
    logic [`XLEN-1:0] opA;
    logic [`XLEN-1:0] opB;
    logic             decValid;
    logic             isMulDiv;
    logic             illegal;
    logic [`XLEN-1:0] aluResult;
    logic             mdStart;
    logic             mdDone;
    logic [`XLEN-1:0] mdResult;

    assign mdStart = decValid && isMulDiv;

    instrDecoder i_instrDecoder (
        .clk        (clk),
        .arstN      (arstN),
        .instrValid (instrValid),
        .instr      (instr),
        .rs1Val     (rs1Val),
        .rs2Val     (rs2Val),
        .busy       (busy),
        .opcode     (opcode),
        .funct3     (funct3),
        .funct7b5   (funct7b5),
        .aluOp      (aluOp),
        .opA        (opA),
        .opB        (opB),
        .decValid   (decValid),
        .isMulDiv   (isMulDiv),
        .illegal    (illegal)
    );

    aluDecoder i_aluDecoder (
        .aluOp    (aluOp),
        .funct3   (funct3),
        .funct7b5 (funct7b5),
        .opcode   (opcode),
        .aluCtrl  (aluCtrl)
    );

    aluCore i_aluCore (
        .aluCtrl   (aluCtrl),
        .opA       (opA),
        .opB       (opB),
        .aluResult (aluResult)
    );

    mulDivUnit i_mulDivUnit (
        .clk      (clk),
        .arstN    (arstN),
        .start    (mdStart),
        .aluCtrl  (aluCtrl),
        .opA      (opA),
        .opB      (opB),
        .busy     (busy),
        .mdDone   (mdDone),
        .mdResult (mdResult)
    );

    resultStage i_resultStage (
        .clk          (clk),
        .arstN        (arstN),
        .decValid     (decValid),
        .isMulDiv     (isMulDiv),
        .illegal      (illegal),
        .funct3       (funct3),
        .opcode       (opcode),
        .aluResult    (aluResult),
        .mdDone       (mdDone),
        .mdResult     (mdResult),
        .result       (result),
        .branchTaken  (branchTaken),
        .illegalInstr (illegalInstr),
        .resultValid  (resultValid)
    );

endmodule

/* source/resultStage.sv */
`timescale 1ns/1ns
`include "exec_config.svh"

module resultStage (
    input  logic             clk,
    input  logic             arstN,
    input  logic             decValid,
    input  logic             isMulDiv,
    input  logic             illegal,
    input  logic [2:0]       funct3,
    input  execPkg::opcodeT  opcode,
    input  logic [`XLEN-1:0] aluResult,
    input  logic             mdDone,
    input  logic [`XLEN-1:0] mdResult,
    output logic [`XLEN-1:0] result,
    output logic             branchTaken,
    output logic             illegalInstr,
    output logic             resultValid
);
    import execPkg::*;

    logic aluPath;
    logic compareTaken;

    assign aluPath = decValid && !isMulDiv;

    always_comb begin
        case (funct3)
            3'b000:         compareTaken = (aluResult == '0);  // BEQ on SUB
            3'b001:         compareTaken = (aluResult != '0);  // BNE
            3'b100, 3'b110: compareTaken = aluResult[0];       // BLT and BLTU
            3'b101, 3'b111: compareTaken = !aluResult[0];      // BGE and BGEU
            default:        compareTaken = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            result       <= '0;
            branchTaken  <= 1'b0;
            illegalInstr <= 1'b0;
            resultValid  <= 1'b0;
        end else begin
            resultValid <= aluPath || mdDone;
            if (aluPath) begin
                result       <= illegal ? '0 : aluResult;
                branchTaken  <= !illegal && (opcode == opBranch) && compareTaken;
                illegalInstr <= illegal;
            end else if (mdDone) begin
                result       <= mdResult;
                branchTaken  <= 1'b0;
                illegalInstr <= 1'b0;
            end
        end
    end

    // Only one result can be written per cycle
    assert property (@(posedge clk) disable iff (!arstN) mdDone |-> !aluPath);

endmodule

/* source/mulDivUnit.sv */
`timescale 1ns/1ns
`include "exec_config.svh"

module mulDivUnit (
    input  logic             clk,
    input  logic             arstN,
    input  logic             start,
    input  execPkg::aluCtrlT aluCtrl,
    input  logic [`XLEN-1:0] opA,
    input  logic [`XLEN-1:0] opB,
    output logic             busy,
    output logic             mdDone,
    output logic [`XLEN-1:0] mdResult
);
    import execPkg::*;

    localparam int CntW = $clog2(`DIV_STEPS);

    typedef enum logic [1:0] {idle, mult, divide, done} mdStateT;

    mdStateT                   state;
    aluCtrlT                   ctrlReg;
    logic [CntW-1:0]           stepCnt;
    logic [2*`XLEN-1:0]        prodReg;
    logic [`XLEN-1:0]          divisor;
    logic [`XLEN-1:0]          quot;
    logic [`XLEN-1:0]          rem;
    logic                      negQuot;
    logic                      negRem;
    logic                      isDiv;
    logic                      divSigned;
    logic                      aSigned;
    logic                      bSigned;
    logic signed [`XLEN:0]     aExt;
    logic signed [`XLEN:0]     bExt;
    logic signed [2*`XLEN+1:0] prodFull;
    logic                      aNeg;
    logic                      bNeg;
    logic [`XLEN-1:0]          aMag;
    logic [`XLEN-1:0]          bMag;
    logic                      divByZero;
    logic                      divOverflow;
    logic [`XLEN:0]            remShift;
    logic [`XLEN:0]            trial;
    logic [`XLEN-1:0]          quotNext;
    logic [`XLEN-1:0]          remNext;
    logic                      lastStep;

    assign isDiv     = aluCtrl inside {ctrlDiv, ctrlDivu, ctrlRem, ctrlRemu};
    assign divSigned = (aluCtrl == ctrlDiv) || (aluCtrl == ctrlRem);
    assign aSigned   = aluCtrl inside {ctrlMul, ctrlMulh, ctrlMulhsu};
    assign bSigned   = aluCtrl inside {ctrlMul, ctrlMulh};

    // One extra bit lets a single signed multiplier cover all sign mixes
    assign aExt     = {aSigned & opA[`XLEN-1], opA};
    assign bExt     = {bSigned & opB[`XLEN-1], opB};
    assign prodFull = aExt * bExt;

    assign aNeg        = divSigned && opA[`XLEN-1];
    assign bNeg        = divSigned && opB[`XLEN-1];
    assign aMag        = aNeg ? -opA : opA;
    assign bMag        = bNeg ? -opB : opB;
    assign divByZero   = (opB == '0);
    assign divOverflow = divSigned && (opA == {1'b1, {(`XLEN-1){1'b0}}}) && (&opB);

    // Restoring step, dividend bits shift out of quot as quotient bits shift in
    assign remShift = {rem, quot[`XLEN-1]};
    assign trial    = remShift - {1'b0, divisor};
    assign quotNext = {quot[`XLEN-2:0], !trial[`XLEN]};
    assign remNext  = trial[`XLEN] ? remShift[`XLEN-1:0] : trial[`XLEN-1:0];
    assign lastStep = (stepCnt == CntW'(`DIV_STEPS - 1));

    assign busy = (state != idle);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state  <= idle;
            mdDone <= 1'b0;
        end else begin
            mdDone <= 1'b0;
            case (state)
                idle: begin
                    if (start) begin
                        if (!isDiv) begin
                            state <= mult;
                        end else if (divByZero || divOverflow) begin
                            state  <= done;  // Shortcut result is ready now
                            mdDone <= 1'b1;
                        end else begin
                            state <= divide;
                        end
                    end
                end
                mult: begin
                    state  <= done;
                    mdDone <= 1'b1;
                end
                divide: begin
                    if (lastStep) begin
                        state  <= done;
                        mdDone <= 1'b1;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            idle: begin
                if (start) begin
                    ctrlReg <= aluCtrl;
                    prodReg <= prodFull[2*`XLEN-1:0];
                    divisor <= bMag;
                    quot    <= aMag;
                    rem     <= '0;
                    stepCnt <= '0;
                    negQuot <= aNeg ^ bNeg;
                    negRem  <= aNeg;  // Remainder follows the dividend sign
                    if (divByZero) begin
                        mdResult <= (aluCtrl inside {ctrlDiv, ctrlDivu}) ? '1 : opA;
                    end else if (divOverflow) begin
                        mdResult <= (aluCtrl == ctrlDiv) ? opA : '0;
                    end
                end
            end
            mult: begin
                if (ctrlReg == ctrlMul) begin
                    mdResult <= prodReg[`XLEN-1:0];
                end else begin
                    mdResult <= prodReg[2*`XLEN-1:`XLEN];
                end
            end
            divide: begin
                quot    <= quotNext;
                rem     <= remNext;
                stepCnt <= stepCnt + 1'b1;
                if (lastStep) begin
                    if (ctrlReg inside {ctrlDiv, ctrlDivu}) begin
                        mdResult <= negQuot ? -quotNext : quotNext;
                    end else begin
                        mdResult <= negRem ? -remNext : remNext;
                    end
                end
            end
            default: ;
        endcase
    end

    // The decoder must hold new M work until the unit is idle
    assert property (@(posedge clk) disable iff (!arstN) start |-> !busy);

endmodule

/* source/aluCore.sv */
`timescale 1ns/1ns
`include "exec_config.svh"

module aluCore (
    input  execPkg::aluCtrlT aluCtrl,
    input  logic [`XLEN-1:0] opA,
    input  logic [`XLEN-1:0] opB,
    output logic [`XLEN-1:0] aluResult
);
    import execPkg::*;

    logic [4:0]       shamt;
    logic [`XLEN-1:0] mulLow;
    logic             signedLess;
    logic             unsignedLess;

    assign shamt        = opB[4:0];  // Only the low 5 bits shift
    assign mulLow       = opA * opB;
    assign signedLess   = $signed(opA) < $signed(opB);
    assign unsignedLess = opA < opB;

    always_comb begin
        case (aluCtrl)
            ctrlAdd:  aluResult = opA + opB;
            ctrlSub:  aluResult = opA - opB;
            ctrlSll:  aluResult = opA << shamt;
            ctrlSlt:  aluResult = {{(`XLEN-1){1'b0}}, signedLess};
            ctrlSltu: aluResult = {{(`XLEN-1){1'b0}}, unsignedLess};
            ctrlXor:  aluResult = opA ^ opB;
            ctrlSrl:  aluResult = opA >> shamt;
            ctrlSra:  aluResult = $signed(opA) >>> shamt;  // Sign fill
            ctrlOr:   aluResult = opA | opB;
            ctrlAnd:  aluResult = opA & opB;
            ctrlMul:  aluResult = mulLow;  // Low product word only
            default:  aluResult = '0;
        endcase
    end

endmodule

/* source/aluDecoder.sv */
`timescale 1ns/1ns

module aluDecoder (
    input  execPkg::aluOpT   aluOp,
    input  logic [2:0]       funct3,
    input  logic             funct7b5,
    input  execPkg::opcodeT  opcode,
    output execPkg::aluCtrlT aluCtrl
);
    import execPkg::*;

    always_comb begin
        case (aluOp)
            aluAdd: aluCtrl = ctrlAdd;  // Load and store address

            aluBranch: begin
                case (funct3)
                    3'b000, 3'b001: aluCtrl = ctrlSub;   // BEQ and BNE
                    3'b100, 3'b101: aluCtrl = ctrlSlt;   // BLT and BGE
                    3'b110, 3'b111: aluCtrl = ctrlSltu;  // BLTU and BGEU
                    default:        aluCtrl = ctrlAdd;
                endcase
            end

            aluRegImm: begin
                case (funct3)
                    3'b000: begin
                        // Bit 30 of an ADDI immediate must not turn it into SUB
                        if (opcode == opReg && funct7b5) begin
                            aluCtrl = ctrlSub;
                        end else begin
                            aluCtrl = ctrlAdd;
                        end
                    end
                    3'b001: aluCtrl = ctrlSll;
                    3'b010: aluCtrl = ctrlSlt;
                    3'b011: aluCtrl = ctrlSltu;
                    3'b100: aluCtrl = ctrlXor;
                    3'b101: aluCtrl = funct7b5 ? ctrlSra : ctrlSrl;
                    3'b110: aluCtrl = ctrlOr;
                    3'b111: aluCtrl = ctrlAnd;
                    default: aluCtrl = ctrlAdd;
                endcase
            end

            aluMulDiv: begin
                case (funct3)
                    3'b000: aluCtrl = ctrlMul;
                    3'b001: aluCtrl = ctrlMulh;
                    3'b010: aluCtrl = ctrlMulhsu;
                    3'b011: aluCtrl = ctrlMulhu;
                    3'b100: aluCtrl = ctrlDiv;
                    3'b101: aluCtrl = ctrlDivu;
                    3'b110: aluCtrl = ctrlRem;   // Distinct from the OR code
                    3'b111: aluCtrl = ctrlRemu;  // Distinct from the AND code
                    default: aluCtrl = ctrlAdd;
                endcase
            end

            default: aluCtrl = ctrlAdd;
        endcase
    end

endmodule

/* source/instrDecoder.sv */
`timescale 1ns/1ns
`include "exec_config.svh"

module instrDecoder (
    input  logic             clk,
    input  logic             arstN,
    input  logic             instrValid,
    input  logic [`XLEN-1:0] instr,
    input  logic [`XLEN-1:0] rs1Val,
    input  logic [`XLEN-1:0] rs2Val,
    input  logic             busy,
    output execPkg::opcodeT  opcode,
    output logic [2:0]       funct3,
    output logic             funct7b5,
    output execPkg::aluOpT   aluOp,
    output logic [`XLEN-1:0] opA,
    output logic [`XLEN-1:0] opB,
    output logic             decValid,
    output logic             isMulDiv,
    output logic             illegal
);
    import execPkg::*;

    logic             accept;
    opcodeT           rawOpcode;
    logic             mExtFunct7;
    logic             knownOpcode;
    logic [`XLEN-1:0] immI;
    logic [`XLEN-1:0] immS;
    logic [`XLEN-1:0] opBNext;
    aluOpT            aluOpNext;

    // Also hold off while a decoded M instruction waits to start
    assign accept = instrValid && !busy && !(decValid && isMulDiv);

    assign rawOpcode  = opcodeT'(instr[6:0]);
    assign mExtFunct7 = (instr[31:25] == 7'b0000001);

    assign immI = {{(`XLEN-12){instr[31]}}, instr[31:20]};
    assign immS = {{(`XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};

    always_comb begin
        knownOpcode = 1'b1;
        opBNext     = immI;
        aluOpNext   = aluAdd;
        case (rawOpcode)
            opReg: begin
                opBNext   = rs2Val;
                aluOpNext = mExtFunct7 ? aluMulDiv : aluRegImm;
            end
            opImm: aluOpNext = aluRegImm;  // Shift amount sits in immI[4:0]
            opBranch: begin
                opBNext   = rs2Val;
                aluOpNext = aluBranch;
            end
            opLoad:  opBNext = immI;
            opStore: opBNext = immS;
            default: knownOpcode = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            decValid <= 1'b0;
            isMulDiv <= 1'b0;
            illegal  <= 1'b0;
        end else begin
            decValid <= accept;
            if (accept) begin
                isMulDiv <= (rawOpcode == opReg) && mExtFunct7;
                illegal  <= !knownOpcode || (mExtFunct7 && rawOpcode != opReg);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            opcode   <= rawOpcode;
            funct3   <= instr[14:12];
            funct7b5 <= instr[30];
            aluOp    <= aluOpNext;
            opA      <= rs1Val;
            opB      <= opBNext;
        end
    end

    // A decoded instruction never overlaps a multiply or divide in flight
    assert property (@(posedge clk) disable iff (!arstN) decValid |-> !busy);

endmodule

/* source/execPkg.sv */
package execPkg;

    // Major opcodes handled by the execute stage
    typedef enum logic [6:0] {
        opLoad   = 7'b0000011,
        opImm    = 7'b0010011,
        opStore  = 7'b0100011,
        opReg    = 7'b0110011,
        opBranch = 7'b1100011
    } opcodeT;

    // Main ALU operation class from the decoder
    typedef enum logic [1:0] {
        aluAdd    = 2'b00,  // Load and store address
        aluBranch = 2'b01,  // Branch compare
        aluRegImm = 2'b10,  // OP and OP-IMM
        aluMulDiv = 2'b11   // M extension
    } aluOpT;

    // Low codes keep the base ALU encoding, M ops get their own codes
    typedef enum logic [4:0] {
        ctrlAdd    = 5'd0,
        ctrlSll    = 5'd1,
        ctrlSlt    = 5'd2,
        ctrlSltu   = 5'd3,
        ctrlXor    = 5'd4,
        ctrlSrl    = 5'd5,
        ctrlOr     = 5'd6,
        ctrlAnd    = 5'd7,
        ctrlSub    = 5'd8,
        ctrlMulhu  = 5'd9,
        ctrlMul    = 5'd10,
        ctrlMulh   = 5'd11,
        ctrlMulhsu = 5'd12,
        ctrlSra    = 5'd13,
        ctrlDiv    = 5'd14,
        ctrlDivu   = 5'd15,
        ctrlRem    = 5'd16,
        ctrlRemu   = 5'd17
    } aluCtrlT;

endpackage

/* source/exec_config.svh */
`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

// Integer datapath width
`define XLEN 32

// Restoring divider produces one quotient bit per step
`define DIV_STEPS `XLEN

`endif
